//--- project.f
+incdir+source
source/oled_pkg.sv
source/oled_init_rom.sv
source/oled_pattern_gen.sv
source/oled_sequencer.sv
source/ssd1351_spi.sv
source/oled_top.sv
dv/oled_tb.sv

//--- dv/oled_tb.sv
// directed testbench with an spi monitor, init table and pattern models and the test tasks.
`timescale 1ns/10ps
`include "oled_cfg.svh"

module oled_tb;
   import oled_pkg::*;

   localparam int INIT_WORDS   = `OLED_INIT_LEN - 1;  // marker is never sent.
   localparam int WORD_TIMEOUT = 200;                 // wait limit in cycles for a word due every 20.
   // init table in send order with one dc bit and one byte per word.
   localparam logic [0:21]  INIT_DC   = 22'b0101_0010_1010_1101_1010_10;
   localparam logic [0:175] INIT_DATA = {8'hFD, 8'h12, 8'hFD, 8'hB1, 8'hAE, 8'hB3, 8'hF1, 8'hCA,
                                         8'h7F, 8'hA0, 8'h74, 8'h15, 8'h00, 8'h7F, 8'h75, 8'h00,
                                         8'h7F, 8'hA1, 8'h00, 8'hA2, 8'h00, 8'hAF};

   logic       clk;
   logic       rst_n;
   oled_pins_t pins;

   oled_word_t word_q[$];        // captured bus words with the oldest first.
   int  tests_passed   = 0;
   int  tests_failed   = 0;
   int  test_errors    = 0;      // errors in the running test.
   int  framing_errors = 0;
   int  early_words    = 0;      // cs windows seen while the panel was in reset.
   int  marker_words   = 0;
   bit  aborted        = 1'b0;   // set when a wait runs out so later tests skip.
   // monitor state.
   logic       prev_cs   = 1'b1;
   logic       prev_sclk = 1'b0;
   logic       window_dc;
   bit         dc_bad;
   int         bit_count;
   byte_t      shift;

   oled_top DUT (.clk(clk), .rst_n(rst_n), .pins(pins));

   initial clk = 1'b0;
   always #5 clk = ~clk;         // 10 ns period.

   // the spi monitor samples on negedge since pins change on posedge.
   always @(negedge clk) begin
      if (rst_n) begin
         if (!pins.cs && prev_cs) begin   // window opens.
            if (!pins.rst)
               early_words++;
            bit_count = 0;
            dc_bad    = 1'b0;
            window_dc = pins.dc;
         end
         if (!pins.cs && !prev_cs && pins.dc !== window_dc && !dc_bad) begin
            $display("framing: dc changed while cs was low");
            framing_errors++;
            dc_bad = 1'b1;
         end
         if (!pins.cs && pins.sclk && !prev_sclk) begin
            shift = {shift[6:0], pins.din};      // mode 0 with msb first.
            bit_count++;
         end
         if (pins.cs && !prev_cs) begin          // window closes on a complete word.
            if (bit_count != 8) begin
               $display("framing: %0d rising sclk edges in a cs window, 8 wanted", bit_count);
               framing_errors++;
            end
            if ({window_dc, shift} == 9'h000)
               marker_words++;
            word_q.push_back({window_dc, shift});
         end
      end
      prev_cs   = pins.cs;
      prev_sclk = pins.sclk;
   end

   function automatic oled_word_t init_word(input int i);
      return {INIT_DC[i], INIT_DATA[8*i +: 8]};
   endfunction

   // byte p of a frame counted from 1 with the high byte of each pixel first.
   function automatic byte_t pattern_byte(input int p, input int f);
      int pix;
      int x;
      int y;
      int colour;
      pix    = (p - 1) / 2;
      x      = pix % `OLED_WIDTH;
      y      = pix / `OLED_WIDTH;
      colour = (((y + f) % 32) << 11) | (((x / 8) % 64) << 5) | ((x + f) % 32);
      if (p % 2 == 1)
         return byte_t'(colour >> 8);
      else
         return byte_t'(colour);
   endfunction

   // waits until the monitor holds a captured word.
   task automatic wait_word(input string name, output bit ok);
      int waited;
      waited = 0;
      ok     = 1'b0;
      if (!aborted) begin
         while (word_q.size() == 0 && waited < WORD_TIMEOUT) begin
            @(posedge clk);
            waited++;
         end
         if (word_q.size() == 0) begin
            $display("%s: timed out waiting for a word on the spi bus", name);
            aborted = 1'b1;
         end else begin
            ok = 1'b1;
         end
      end
   endtask

   task automatic next_word(input string name, output oled_word_t w, output bit ok);
      w = '0;
      wait_word(name, ok);
      if (ok)
         w = word_q.pop_front();
   endtask

   task automatic compare_word(input string name, input oled_word_t exp_w, input oled_word_t act);
      if (act !== exp_w) begin
         $display("error %s expected dc %0b data %02h actual dc %0b data %02h",
                  name, exp_w.dc, exp_w.data, act.dc, act.data);
         test_errors++;
      end
   endtask

   task automatic close_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic reset_pulse();
      int cycles;
      cycles = 1;
      @(negedge clk);                          // first cycle out of reset.
      if (pins.cs !== 1'b1 || pins.rst !== 1'b0) begin
         $display("error reset expected cs 1 rst 0 actual cs %b rst %b", pins.cs, pins.rst);
         test_errors++;
      end
      while (pins.rst !== 1'b1 && cycles < 4 * `OLED_RST_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (pins.rst !== 1'b1) begin
         $display("reset: timed out waiting for the panel reset pin to rise");
         test_errors++;
         aborted = 1'b1;
      end else if (cycles < `OLED_RST_CYCLES) begin
         $display("error reset expected %0d cycles actual %0d", `OLED_RST_CYCLES, cycles);
         test_errors++;
      end
      if (early_words != 0 || word_q.size() != 0) begin
         $display("reset: a word was sent before the panel reset ended");
         test_errors++;
      end
      close_test("reset");
   endtask

   task automatic init_stream();
      oled_word_t w;
      bit         ok;
      int         i;
      ok = 1'b1;
      i  = 0;
      while (i < INIT_WORDS && ok) begin
         next_word("init", w, ok);
         if (ok)
            compare_word("init", init_word(i), w);
         i++;
      end
      if (ok)
         wait_word("init", ok);               // a sent marker would be this next word.
      if (!ok)
         test_errors++;
      if (marker_words != 0) begin
         $display("init: the end marker was sent on the bus");
         test_errors++;
      end
      close_test("init");
   endtask

   task automatic expect_wram(input string name);
      oled_word_t w;
      bit         ok;
      next_word(name, w, ok);
      if (ok)
         compare_word(name, {1'b0, `OLED_CMD_WRAM}, w);
      else
         test_errors++;
   endtask

   // count bytes of frame f that must also differ from frame f-1.
   task automatic pixel_bytes(input string name, input int f, input int count);
      oled_word_t w;
      bit         ok;
      int         p;
      int         unchanged;
      ok        = 1'b1;
      p         = 1;
      unchanged = 0;
      while (p <= count && ok) begin
         next_word(name, w, ok);
         if (ok) begin
            compare_word(name, {1'b1, pattern_byte(p, f)}, w);
            if (f != 0 && w.data == pattern_byte(p, f - 1))
               unchanged++;
         end
         p++;
      end
      if (!ok)
         test_errors++;
      if (unchanged != 0) begin
         $display("%s: %0d bytes did not change from the previous frame", name, unchanged);
         test_errors++;
      end
   endtask

   task automatic frame_start();
      expect_wram("frame_start");
      close_test("frame_start");
   endtask

   task automatic first_frame();
      pixel_bytes("frame0", 0, `OLED_PIXEL_BYTES);
      close_test("frame0");
   endtask

   task automatic second_frame();
      expect_wram("frame1");
      pixel_bytes("frame1", 1, 512);
      close_test("frame1");
   endtask

   task automatic bus_framing();
      test_errors = framing_errors;             // cs window faults counted by the monitor.
      close_test("framing");
   endtask

   initial begin
      rst_n = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;                             // released on a falling edge.
      reset_pulse();
      init_stream();
      frame_start();
      first_frame();
      second_frame();
      bus_framing();
      $display("tests passed %0d failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && !aborted) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- source/oled_top.sv
// top level wiring the sequencer, init rom, pattern generator and spi serializer to the panel.
`timescale 1ns/10ps

module oled_top (
   input  logic                 clk,
   input  logic                 rst_n,
   output oled_pkg::oled_pins_t pins
);
   import oled_pkg::*;

   pc_t        pc;          // rom address and pixel byte index.
   frame_t     frame;
   oled_word_t rom_word;
   byte_t      pixel_byte;
   oled_word_t word;        // sequencer to serializer.
   logic       wr;
   logic       busy;

   oled_sequencer u_seq (
      .clk        (clk),
      .rst_n      (rst_n),
      .busy       (busy),
      .rom_word   (rom_word),
      .pixel_byte (pixel_byte),
      .pc         (pc),
      .frame      (frame),
      .wr         (wr),
      .word       (word)
   );

   oled_init_rom u_rom (
      .addr (pc),
      .word (rom_word)
   );

   oled_pattern_gen u_pat (
      .pixel_index (pc),
      .frame       (frame),
      .pixel_byte  (pixel_byte)
   );

   ssd1351_spi u_spi (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (wr),
      .word  (word),
      .busy  (busy),
      .pins  (pins)   // only output of the top.
   );

endmodule

//--- source/ssd1351_spi.sv
// spi mode 0 word serializer with cs and dc framing and the panel reset pulse.
`timescale 1ns/10ps
`include "oled_cfg.svh"

module ssd1351_spi (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wr,
   input  oled_pkg::oled_word_t word,
   output logic                 busy,
   output oled_pkg::oled_pins_t pins
);
   import oled_pkg::*;

   localparam int RST_W = $clog2(`OLED_RST_CYCLES + 1);

   typedef enum logic [1:0] {
      IDLE,     // waiting for wr.
      SHIFT,    // clocking out 8 bits.
      RELEASE   // raise cs and drop busy.
   } spi_state_t;

   spi_state_t       state;
   logic [RST_W-1:0] rst_cnt;   // panel reset pulse length.
   logic [2:0]       bit_cnt;   // bits already clocked.
   byte_t            shreg;     // remaining bits with msb next.

   logic accept;
   assign accept = wr && !busy && (state == IDLE);

   // data shift register loaded on accept.
   always_ff @(posedge clk) begin
      if (accept) begin
         shreg <= word.data;
      end else if (state == SHIFT && pins.sclk) begin
         shreg <= shreg << 1;                     // next bit after falling edge.
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= IDLE;
         rst_cnt   <= '0;
         bit_cnt   <= '0;
         busy      <= 1'b1;                       // held until the reset pulse ends.
         pins.din  <= 1'b0;
         pins.sclk <= 1'b0;
         pins.cs   <= 1'b1;
         pins.dc   <= 1'b0;
         pins.rst  <= 1'b0;                       // panel in reset.
      end else if (!pins.rst) begin
         rst_cnt <= rst_cnt + RST_W'(1);
         if (rst_cnt == RST_W'(`OLED_RST_CYCLES - 1)) begin
            pins.rst <= 1'b1;                     // release the panel and open the bus.
            busy     <= 1'b0;
         end
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  state    <= SHIFT;
                  busy     <= 1'b1;
                  bit_cnt  <= '0;
                  pins.cs  <= 1'b0;
                  pins.dc  <= word.dc;            // held for the whole cs window.
                  pins.din <= word.data[7];       // msb first.
               end
            end
            SHIFT: begin
               pins.sclk <= !pins.sclk;           // clk/2 with din sampled on the rising edge.
               if (pins.sclk) begin
                  pins.din <= shreg[6];           // change din while sclk is low.
                  bit_cnt  <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     state <= RELEASE;            // eighth falling edge.
                  end
               end
            end
            RELEASE: begin
               pins.cs <= 1'b1;
               busy    <= 1'b0;
               state   <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

//--- source/oled_sequencer.sv
// program counter and fsm for the init table, write-ram command and pixel stream.
`timescale 1ns/10ps
`include "oled_cfg.svh"

module oled_sequencer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 busy,       // serializer cannot take a word.
   input  oled_pkg::oled_word_t rom_word,   // init table entry at pc.
   input  oled_pkg::byte_t      pixel_byte, // pattern byte at pc.
   output oled_pkg::pc_t        pc,
   output oled_pkg::frame_t     frame,
   output logic                 wr,
   output oled_pkg::oled_word_t word
);
   import oled_pkg::*;

   seq_state_t state;
   logic       in_flight;   // word accepted and serializer not done yet.

   // word on offer follows the state and pc and stays stable while busy.
   always_comb begin
      case (state)
         INIT:     word = rom_word;
         WRAM_CMD: word = '{dc: 1'b0, data: `OLED_CMD_WRAM};
         PIXELS:   word = '{dc: 1'b1, data: pixel_byte};
         default:  word = `OLED_END_MARKER;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= INIT;
         pc        <= '0;
         frame     <= '0;
         wr        <= 1'b0;
         in_flight <= 1'b0;
      end else begin
         wr <= 1'b0;                              // strobe is one cycle wide.
         if (wr) begin
            in_flight <= 1'b1;                    // busy rises next cycle.
         end else if (in_flight) begin
            if (!busy) begin                      // transfer finished so step on.
               in_flight <= 1'b0;
               case (state)
                  INIT: begin
                     pc <= pc + pc_t'(1);
                  end
                  WRAM_CMD: begin
                     state <= PIXELS;
                     pc    <= pc_t'(1);           // first pixel byte.
                  end
                  PIXELS: begin
                     if (pc == pc_t'(`OLED_PIXEL_BYTES)) begin
                        state <= WRAM_CMD;        // frame done so start the next one.
                        pc    <= '0;
                        frame <= frame + frame_t'(1);
                     end else begin
                        pc <= pc + pc_t'(1);
                     end
                  end
                  default: begin
                     state <= INIT;
                     pc    <= '0;
                  end
               endcase
            end
         end else if (!busy) begin
            // marker ends the init table and is not sent.
            if (state == INIT && rom_word == `OLED_END_MARKER) begin
               state <= WRAM_CMD;
               pc    <= '0;
            end else begin
               wr <= 1'b1;                        // offer the current word.
            end
         end
      end
   end

endmodule

//--- source/oled_pattern_gen.sv
// rgb565 test pattern byte from the frame byte index and frame count.
`timescale 1ns/10ps
`include "oled_cfg.svh"

module oled_pattern_gen (
   input  oled_pkg::pc_t    pixel_index,
   input  oled_pkg::frame_t frame,
   output oled_pkg::byte_t  pixel_byte
);
   import oled_pkg::*;

   pc_t        pix_num;  // pixel number inside the frame.
   coord_t     x;
   coord_t     y;
   logic [4:0] red;
   logic [5:0] green;
   logic [4:0] blue;
   rgb565_t    colour;

   // index 0 is the write-ram command so pixel bytes start at 1.
   assign pix_num = (pixel_index - pc_t'(1)) >> 1;

   // raster order, row after row.
   assign x = coord_t'(pix_num % `OLED_WIDTH);
   assign y = coord_t'(pix_num / `OLED_WIDTH);

   // blue and red scroll with the frame count and wrap at 32.
   assign blue  = x[4:0] + frame[4:0];
   assign red   = y[4:0] + frame[4:0];
   assign green = 6'(x >> 3);                 // coarse horizontal ramp.

   assign colour = {red, green, blue};         // rgb565 packing.

   // odd index carries the high byte, which goes out first.
   assign pixel_byte = pixel_index[0] ? colour[15:8] : colour[7:0];

endmodule

//--- source/oled_init_rom.sv
// combinational table of the ssd1351 init command words.
`timescale 1ns/10ps
`include "oled_cfg.svh"

module oled_init_rom (
   input  oled_pkg::pc_t       addr,
   output oled_pkg::oled_word_t word
);
   import oled_pkg::*;

   // command byte with dc low.
   function automatic oled_word_t cmd(input byte_t b);
      return '{dc: 1'b0, data: b};
   endfunction

   // argument byte with dc high.
   function automatic oled_word_t arg(input byte_t b);
      return '{dc: 1'b1, data: b};
   endfunction

   always_comb begin
      case (addr)
         16'd0:   word = cmd(8'hFD);         // command lock.
         16'd1:   word = arg(8'h12);         // unlock the controller.
         16'd2:   word = cmd(8'hFD);
         16'd3:   word = arg(8'hB1);         // unlock the restricted commands.
         16'd4:   word = cmd(8'hAE);         // display off while configuring.
         16'd5:   word = cmd(8'hB3);         // clock divider and oscillator.
         16'd6:   word = arg(8'hF1);
         16'd7:   word = cmd(8'hCA);         // mux ratio.
         16'd8:   word = arg(8'h7F);         // 128 rows.
         16'd9:   word = cmd(8'hA0);         // remap and colour depth.
         16'd10:  word = arg(8'h74);         // 65k colours with com split.
         16'd11:  word = cmd(8'h15);         // column window.
         16'd12:  word = arg(8'h00);
         16'd13:  word = arg(8'h7F);
         16'd14:  word = cmd(8'h75);         // row window.
         16'd15:  word = arg(8'h00);
         16'd16:  word = arg(8'h7F);
         16'd17:  word = cmd(8'hA1);         // start line.
         16'd18:  word = arg(8'h00);
         16'd19:  word = cmd(8'hA2);         // display offset.
         16'd20:  word = arg(8'h00);
         16'd21:  word = cmd(8'hAF);         // display on.
         default: word = `OLED_END_MARKER;   // end marker at the table end and beyond.
      endcase
   end

endmodule

//--- source/oled_pkg.sv
// bus, colour, coordinate and counter types, word and pin structs and the sequencer state enum.
`include "oled_cfg.svh"

package oled_pkg;

   typedef logic [7:0]                    byte_t;   // one byte on the spi bus.
   typedef logic [15:0]                   rgb565_t; // red 5 bits on top of green 6 and blue 5.
   typedef logic [`OLED_COORD_BITS-1:0]   coord_t;  // one x or y position.
   typedef logic [15:0]                   pc_t;     // init index or frame byte index.
   typedef logic [31:0]                   frame_t;  // frames written since reset.

   // one word for the serializer.
   typedef struct packed {
      logic  dc;   // 0 command and 1 data.
      byte_t data;
   } oled_word_t;

   // panel side of the 4-wire spi link.
   typedef struct packed {
      logic din;  // serial data in spi mode 0.
      logic sclk;
      logic cs;   // active low.
      logic dc;
      logic rst;  // active low panel reset.
   } oled_pins_t;

   // sequencer phases.
   typedef enum logic [1:0] {
      INIT,     // streaming the init rom.
      WRAM_CMD, // sending 0x5c.
      PIXELS    // sending pixel bytes.
   } seq_state_t;

endpackage

//--- source/oled_cfg.svh
// panel geometry, reset pulse length, init table length and bus word constants.
`ifndef OLED_CFG_SVH
`define OLED_CFG_SVH

// panel size in pixels.
`define OLED_WIDTH 128
`define OLED_HEIGHT 128

// bits of one x or y coordinate.
`define OLED_COORD_BITS 7

// clk cycles the panel reset pin stays low after rst_n releases.
`define OLED_RST_CYCLES 64

// init table entries, end marker included.
// 22 command and argument words, then the marker.
`define OLED_INIT_LEN 23

// all-zero bus word that ends the init table, never sent.
`define OLED_END_MARKER 9'h000

// write-RAM command that opens every frame.
`define OLED_CMD_WRAM 8'h5C

// bytes in one full frame, two per pixel.
`define OLED_PIXEL_BYTES (2 * `OLED_WIDTH * `OLED_HEIGHT)

`endif
